// File: rtl/lsq_pkg.sv
// Shared sizing for the LSQ; LSQ_ENTRIES must equal 2**LSQ_INDEX_WIDTH so the pointers wrap
package lsq_pkg;

  ////////////////////
  // Core widths
  ////////////////////

  // Reorder-buffer tag, 32 tags in flight
  localparam int TAG_WIDTH = 5;

  // Byte address, word-aligned accesses only
  localparam int ADDR_WIDTH = 32;

  localparam int DATA_WIDTH = 32;

  ////////////////////
  // Queue sizing
  ////////////////////

  localparam int LSQ_ENTRIES = 8;
  localparam int LSQ_INDEX_WIDTH = 3;

  ////////////////////
  // AXI4-Lite
  ////////////////////

  // Only OKAY is expected back from memory
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// File: rtl/lsq_entry.sv
// One queue slot; assumes a tag is held by at most one live entry, a repeated result overwrites
module lsq_entry import lsq_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // Queue control
  input  logic                  clear,
  input  logic                  alloc,
  input  logic [TAG_WIDTH-1:0]  alloc_tag,
  input  logic                  alloc_load,
  // Execute port 0
  input  logic                  ex_0_valid,
  input  logic [TAG_WIDTH-1:0]  ex_0_tag,
  input  logic [ADDR_WIDTH-1:0] ex_0_addr,
  input  logic [DATA_WIDTH-1:0] ex_0_data,
  // Execute port 1
  input  logic                  ex_1_valid,
  input  logic [TAG_WIDTH-1:0]  ex_1_tag,
  input  logic [ADDR_WIDTH-1:0] ex_1_addr,
  input  logic [DATA_WIDTH-1:0] ex_1_data,
  // Stored state
  output logic                  valid,
  output logic                  load,
  output logic [TAG_WIDTH-1:0]  tag,
  output logic [ADDR_WIDTH-1:0] addr,
  output logic [DATA_WIDTH-1:0] data,
  output logic                  complete
);

  logic                 live;
  logic [TAG_WIDTH-1:0] match_tag;
  logic                 hit_0;
  logic                 hit_1;

  // A result can land in the same cycle the slot is allocated
  assign live      = valid | alloc;
  assign match_tag = alloc ? alloc_tag : tag;
  assign hit_0     = live & ex_0_valid & (ex_0_tag == match_tag);
  assign hit_1     = live & ex_1_valid & (ex_1_tag == match_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= 1'b0;
      complete <= 1'b0;
    end else if (clear) begin
      valid    <= 1'b0;
      complete <= 1'b0;
    end else begin
      if (alloc)
        valid <= 1'b1;
      if (hit_0 | hit_1)
        complete <= 1'b1;
      else if (alloc)
        complete <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      tag  <= alloc_tag;
      load <= alloc_load;
    end
    // Port 0 wins when both ports carry this tag
    if (hit_0) begin
      addr <= ex_0_addr;
      data <= ex_0_data;
    end else if (hit_1) begin
      addr <= ex_1_addr;
      data <= ex_1_data;
    end
  end

  // Queue must only allocate into a free slot, never while popping it
  a_alloc_free: assert property (@(posedge clock) disable iff (reset)
    alloc |-> !valid && !clear)
    else $error("lsq_entry: allocation into a live or clearing slot");

endmodule

// File: rtl/lsq_dispatch.sv
// Two-wide dispatch register; slot 0 is older than slot 1, an op with both load and store is a load
module lsq_dispatch import lsq_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // Decoded pair from the front end
  input  logic                 slot_0_valid,
  input  logic [TAG_WIDTH-1:0] slot_0_tag,
  input  logic                 slot_0_load,
  input  logic                 slot_0_store,
  input  logic                 slot_1_valid,
  input  logic [TAG_WIDTH-1:0] slot_1_tag,
  input  logic                 slot_1_load,
  input  logic                 slot_1_store,
  output logic                 dispatch_ready,
  // Toward the queue
  input  logic                 queue_room,
  output logic                 alloc_0_valid,
  output logic [TAG_WIDTH-1:0] alloc_0_tag,
  output logic                 alloc_0_load,
  output logic                 alloc_1_valid,
  output logic [TAG_WIDTH-1:0] alloc_1_tag,
  output logic                 alloc_1_load
);

  logic mem_0;
  logic mem_1;

  // Non-memory ops never reach the queue
  assign mem_0 = slot_0_valid & (slot_0_load | slot_0_store);
  assign mem_1 = slot_1_valid & (slot_1_load | slot_1_store);

  // Register is refilled only when the queue takes its current pair
  assign dispatch_ready = queue_room;

  always_ff @(posedge clock) begin
    if (reset) begin
      alloc_0_valid <= 1'b0;
      alloc_1_valid <= 1'b0;
    end else if (queue_room) begin
      alloc_0_valid <= mem_0 | mem_1;
      alloc_1_valid <= mem_0 & mem_1;
    end
  end

  // Compaction: a lone slot 1 op moves to position 0
  always_ff @(posedge clock) begin
    if (queue_room) begin
      alloc_0_tag  <= mem_0 ? slot_0_tag : slot_1_tag;
      alloc_0_load <= mem_0 ? slot_0_load : slot_1_load;
      alloc_1_tag  <= slot_1_tag;
      alloc_1_load <= slot_1_load;
    end
  end

  a_alloc_order: assert property (@(posedge clock) disable iff (reset)
    alloc_1_valid |-> alloc_0_valid)
    else $error("lsq_dispatch: second allocation without the first");

endmodule

// File: rtl/lsq_queue.sv
// In-order LSQ; a store leaves only with its tag among the two rob heads, no forwarding or flush
module lsq_queue import lsq_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // Allocation from dispatch
  input  logic                  alloc_0_valid,
  input  logic [TAG_WIDTH-1:0]  alloc_0_tag,
  input  logic                  alloc_0_load,
  input  logic                  alloc_1_valid,
  input  logic [TAG_WIDTH-1:0]  alloc_1_tag,
  input  logic                  alloc_1_load,
  output logic                  queue_room,
  // Execute results
  input  logic                  ex_0_valid,
  input  logic [TAG_WIDTH-1:0]  ex_0_tag,
  input  logic [ADDR_WIDTH-1:0] ex_0_addr,
  input  logic [DATA_WIDTH-1:0] ex_0_data,
  input  logic                  ex_1_valid,
  input  logic [TAG_WIDTH-1:0]  ex_1_tag,
  input  logic [ADDR_WIDTH-1:0] ex_1_addr,
  input  logic [DATA_WIDTH-1:0] ex_1_data,
  // Commit window
  input  logic [TAG_WIDTH-1:0]  rob_head_0,
  input  logic [TAG_WIDTH-1:0]  rob_head_1,
  // Head toward the memory port
  output logic                  head_valid,
  output logic                  head_load,
  output logic [TAG_WIDTH-1:0]  head_tag,
  output logic [ADDR_WIDTH-1:0] head_addr,
  output logic [DATA_WIDTH-1:0] head_data,
  input  logic                  head_ready
);

  logic [LSQ_INDEX_WIDTH-1:0] head_ptr;
  logic [LSQ_INDEX_WIDTH-1:0] tail_ptr;
  logic [LSQ_INDEX_WIDTH-1:0] tail_next;
  logic [LSQ_INDEX_WIDTH:0]   count;
  logic                       do_alloc_0;
  logic                       do_alloc_1;
  logic [1:0]                 alloc_count;
  logic                       pop;

  logic [LSQ_ENTRIES-1:0] ent_alloc;
  logic [LSQ_ENTRIES-1:0] ent_clear;
  logic [LSQ_ENTRIES-1:0] ent_valid;
  logic [LSQ_ENTRIES-1:0] ent_load;
  logic [LSQ_ENTRIES-1:0] ent_complete;
  logic [TAG_WIDTH-1:0]   ent_tag  [LSQ_ENTRIES];
  logic [ADDR_WIDTH-1:0]  ent_addr [LSQ_ENTRIES];
  logic [DATA_WIDTH-1:0]  ent_data [LSQ_ENTRIES];

  ////////////////////
  // Allocation
  ////////////////////

  // Room for a full pair, so a held pair is never split
  assign queue_room  = count <= (LSQ_INDEX_WIDTH + 1)'(LSQ_ENTRIES - 2);
  assign do_alloc_0  = alloc_0_valid & queue_room;
  assign do_alloc_1  = alloc_1_valid & queue_room;
  assign alloc_count = {1'b0, do_alloc_0} + {1'b0, do_alloc_1};
  assign tail_next   = tail_ptr + 1'b1;

  for (genvar i = 0; i < LSQ_ENTRIES; i++) begin : g_entry
    logic at_tail;

    assign at_tail = (tail_ptr == LSQ_INDEX_WIDTH'(i));
    assign ent_alloc[i] = (do_alloc_0 & at_tail) |
                          (do_alloc_1 & (tail_next == LSQ_INDEX_WIDTH'(i)));
    assign ent_clear[i] = pop & (head_ptr == LSQ_INDEX_WIDTH'(i));

    lsq_entry u_entry (
      .clock      (clock),
      .reset      (reset),
      .clear      (ent_clear[i]),
      .alloc      (ent_alloc[i]),
      .alloc_tag  (at_tail ? alloc_0_tag : alloc_1_tag),
      .alloc_load (at_tail ? alloc_0_load : alloc_1_load),
      .ex_0_valid (ex_0_valid),
      .ex_0_tag   (ex_0_tag),
      .ex_0_addr  (ex_0_addr),
      .ex_0_data  (ex_0_data),
      .ex_1_valid (ex_1_valid),
      .ex_1_tag   (ex_1_tag),
      .ex_1_addr  (ex_1_addr),
      .ex_1_data  (ex_1_data),
      .valid      (ent_valid[i]),
      .load       (ent_load[i]),
      .tag        (ent_tag[i]),
      .addr       (ent_addr[i]),
      .data       (ent_data[i]),
      .complete   (ent_complete[i])
    );
  end

  ////////////////////
  // Head and commit
  ////////////////////

  assign head_load = ent_load[head_ptr];
  assign head_tag  = ent_tag[head_ptr];
  assign head_addr = ent_addr[head_ptr];
  assign head_data = ent_data[head_ptr];

  // Loads go once complete, stores also wait for the commit window
  assign head_valid = ent_valid[head_ptr] & ent_complete[head_ptr] &
                      (head_load | (head_tag == rob_head_0) | (head_tag == rob_head_1));
  assign pop = head_valid & head_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (pop)
        head_ptr <= head_ptr + 1'b1;
      tail_ptr <= tail_ptr + LSQ_INDEX_WIDTH'(alloc_count);
      count    <= count + (LSQ_INDEX_WIDTH + 1)'(alloc_count)
                        - (LSQ_INDEX_WIDTH + 1)'(pop);
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= (LSQ_INDEX_WIDTH + 1)'(LSQ_ENTRIES))
    else $error("lsq_queue: occupancy above queue depth");

endmodule

// File: rtl/lsq_mem_port.sv
// One AXI4-Lite transaction at a time, full-word strobes only; non-OKAY responses are not handled
module lsq_mem_port import lsq_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  // Queue head
  input  logic                    head_valid,
  input  logic                    head_load,
  input  logic [TAG_WIDTH-1:0]    head_tag,
  input  logic [ADDR_WIDTH-1:0]   head_addr,
  input  logic [DATA_WIDTH-1:0]   head_data,
  output logic                    head_ready,
  // AXI4-Lite master
  output logic                    awvalid,
  input  logic                    awready,
  output logic [ADDR_WIDTH-1:0]   awaddr,
  output logic                    wvalid,
  input  logic                    wready,
  output logic [DATA_WIDTH-1:0]   wdata,
  output logic [DATA_WIDTH/8-1:0] wstrb,
  input  logic                    bvalid,
  output logic                    bready,
  input  logic [1:0]              bresp,
  output logic                    arvalid,
  input  logic                    arready,
  output logic [ADDR_WIDTH-1:0]   araddr,
  input  logic                    rvalid,
  output logic                    rready,
  input  logic [DATA_WIDTH-1:0]   rdata,
  input  logic [1:0]              rresp,
  // Completion report
  output logic                    done_valid,
  output logic [TAG_WIDTH-1:0]    done_tag,
  output logic                    done_load,
  output logic [DATA_WIDTH-1:0]   done_data
);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_data,
    st_write,
    st_wr_resp
  } state_t;

  state_t                state;
  logic [TAG_WIDTH-1:0]  op_tag;
  logic                  op_load;
  logic [ADDR_WIDTH-1:0] op_addr;
  logic [DATA_WIDTH-1:0] op_data;
  logic                  aw_done;
  logic                  w_done;
  logic                  pop;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  ar_fire;
  logic                  b_fire;
  logic                  r_fire;

  assign head_ready = (state == st_idle);
  assign pop        = head_valid & head_ready;

  // aw and w each drop once their own handshake is done
  assign awvalid = (state == st_write) & ~aw_done;
  assign wvalid  = (state == st_write) & ~w_done;
  assign arvalid = (state == st_rd_addr);
  assign bready  = (state == st_wr_resp);
  assign rready  = (state == st_rd_data);

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign ar_fire = arvalid & arready;
  assign b_fire  = bvalid & bready;
  assign r_fire  = rvalid & rready;

  assign awaddr    = op_addr;
  assign araddr    = op_addr;
  assign wdata     = op_data;
  assign wstrb     = '1;
  assign done_tag  = op_tag;
  assign done_load = op_load;

  ////////////////////
  // Transaction FSM
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      done_valid <= r_fire | b_fire;
      case (state)
        st_idle:
          if (pop)
            state <= head_load ? st_rd_addr : st_write;
        st_rd_addr:
          if (ar_fire)
            state <= st_rd_data;
        st_rd_data:
          if (r_fire)
            state <= st_idle;
        st_write: begin
          if (aw_fire)
            aw_done <= 1'b1;
          if (w_fire)
            w_done <= 1'b1;
          if ((aw_done | aw_fire) & (w_done | w_fire)) begin
            state   <= st_wr_resp;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        st_wr_resp:
          if (b_fire)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  // Operation captured at pop, held until the port is idle again
  always_ff @(posedge clock) begin
    if (pop) begin
      op_tag  <= head_tag;
      op_load <= head_load;
      op_addr <= head_addr;
      op_data <= head_data;
    end
    if (r_fire)
      done_data <= rdata;
    else if (b_fire)
      done_data <= op_data;
  end

  ////////////////////
  // Bus checks
  ////////////////////

  a_resp_okay: assert property (@(posedge clock) disable iff (reset)
    (b_fire |-> bresp == AXI_RESP_OKAY) and (r_fire |-> rresp == AXI_RESP_OKAY))
    else $error("lsq_mem_port: memory returned a non-OKAY response");

  a_aw_stable: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("lsq_mem_port: aw changed while waiting");

  a_w_stable: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("lsq_mem_port: w changed while waiting");

  a_ar_stable: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("lsq_mem_port: ar changed while waiting");

endmodule

// File: rtl/lsq_top.sv
// LSQ subsystem top; rob heads must track the two oldest uncommitted tags or stores never leave
module lsq_top import lsq_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  // Dispatch pair
  input  logic                    slot_0_valid,
  input  logic [TAG_WIDTH-1:0]    slot_0_tag,
  input  logic                    slot_0_load,
  input  logic                    slot_0_store,
  input  logic                    slot_1_valid,
  input  logic [TAG_WIDTH-1:0]    slot_1_tag,
  input  logic                    slot_1_load,
  input  logic                    slot_1_store,
  output logic                    dispatch_ready,
  // Execute ports
  input  logic                    ex_0_valid,
  input  logic [TAG_WIDTH-1:0]    ex_0_tag,
  input  logic [ADDR_WIDTH-1:0]   ex_0_addr,
  input  logic [DATA_WIDTH-1:0]   ex_0_data,
  input  logic                    ex_1_valid,
  input  logic [TAG_WIDTH-1:0]    ex_1_tag,
  input  logic [ADDR_WIDTH-1:0]   ex_1_addr,
  input  logic [DATA_WIDTH-1:0]   ex_1_data,
  // Commit window
  input  logic [TAG_WIDTH-1:0]    rob_head_0,
  input  logic [TAG_WIDTH-1:0]    rob_head_1,
  // AXI4-Lite toward memory
  output logic                    awvalid,
  input  logic                    awready,
  output logic [ADDR_WIDTH-1:0]   awaddr,
  output logic                    wvalid,
  input  logic                    wready,
  output logic [DATA_WIDTH-1:0]   wdata,
  output logic [DATA_WIDTH/8-1:0] wstrb,
  input  logic                    bvalid,
  output logic                    bready,
  input  logic [1:0]              bresp,
  output logic                    arvalid,
  input  logic                    arready,
  output logic [ADDR_WIDTH-1:0]   araddr,
  input  logic                    rvalid,
  output logic                    rready,
  input  logic [DATA_WIDTH-1:0]   rdata,
  input  logic [1:0]              rresp,
  // Completion
  output logic                    done_valid,
  output logic [TAG_WIDTH-1:0]    done_tag,
  output logic                    done_load,
  output logic [DATA_WIDTH-1:0]   done_data
);

  // Dispatch to queue
  logic                  queue_room;
  logic                  alloc_0_valid;
  logic [TAG_WIDTH-1:0]  alloc_0_tag;
  logic                  alloc_0_load;
  logic                  alloc_1_valid;
  logic [TAG_WIDTH-1:0]  alloc_1_tag;
  logic                  alloc_1_load;

  // Queue head to memory port
  logic                  head_valid;
  logic                  head_load;
  logic [TAG_WIDTH-1:0]  head_tag;
  logic [ADDR_WIDTH-1:0] head_addr;
  logic [DATA_WIDTH-1:0] head_data;
  logic                  head_ready;

  // Port names match across the hierarchy
  lsq_dispatch u_dispatch (.*);

  lsq_queue u_queue (.*);

  lsq_mem_port u_mem_port (.*);

endmodule

// File: dv/lsq_axi_mem.sv
// Testbench AXI4-Lite slave; word index is the address modulo MEM_WORDS, strobes ignored, OKAY only
module lsq_axi_mem import lsq_pkg::*; #(
  parameter int MEM_WORDS = 16
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [ADDR_WIDTH-1:0]   awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [DATA_WIDTH-1:0]   wdata,
  input  logic [DATA_WIDTH/8-1:0] wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [1:0]              bresp,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [ADDR_WIDTH-1:0]   araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [DATA_WIDTH-1:0]   rdata,
  output logic [1:0]              rresp
);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  integer                seed;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  ar_fire;
  logic                  b_fire;
  logic                  r_fire;
  logic [ADDR_WIDTH-1:0] aw_addr_q;
  logic [ADDR_WIDTH-1:0] ar_addr_q;
  logic [DATA_WIDTH-1:0] w_data_q;
  logic                  aw_held;
  logic                  w_held;
  logic                  b_wait;
  logic                  r_wait;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  assign bresp = AXI_RESP_OKAY;
  assign rresp = AXI_RESP_OKAY;

  initial begin
    seed    = 32'h18c0_a548;
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    bvalid  = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'h6d6d_0000 ^ (32'(i) << 2);
  end

  // Handshakes as seen by the master at the rising edge
  always @(posedge clock) begin
    aw_fire   <= awvalid & awready;
    w_fire    <= wvalid & wready;
    ar_fire   <= arvalid & arready;
    b_fire    <= bvalid & bready;
    r_fire    <= rvalid & rready;
    aw_addr_q <= awaddr;
    ar_addr_q <= araddr;
    w_data_q  <= wdata;
  end

  ////////////////////
  // Response side, updated on the falling edge
  ////////////////////

  always @(negedge clock) begin
    if (reset) begin
      awready = 1'b0;
      wready  = 1'b0;
      arready = 1'b0;
      bvalid  = 1'b0;
      rvalid  = 1'b0;
      aw_held = 1'b0;
      w_held  = 1'b0;
      b_wait  = 1'b0;
      r_wait  = 1'b0;
    end else begin
      if (aw_fire) begin
        aw_held = 1'b1;
        wr_addr = aw_addr_q;
      end
      if (w_fire) begin
        w_held  = 1'b1;
        wr_data = w_data_q;
      end
      // Write lands once both halves are in
      if (aw_held && w_held) begin
        mem[int'(wr_addr >> 2) % MEM_WORDS] = wr_data;
        aw_held = 1'b0;
        w_held  = 1'b0;
        b_wait  = 1'b1;
      end
      if (ar_fire) begin
        rd_addr = ar_addr_q;
        r_wait  = 1'b1;
      end
      if (b_fire)
        bvalid = 1'b0;
      if (r_fire)
        rvalid = 1'b0;
      // Random response delay
      if (b_wait && ($random(seed) & 1) != 0) begin
        bvalid = 1'b1;
        b_wait = 1'b0;
      end
      if (r_wait && ($random(seed) & 1) != 0) begin
        rdata  = mem[int'(rd_addr >> 2) % MEM_WORDS];
        rvalid = 1'b1;
        r_wait = 1'b0;
      end
      awready = !aw_held && ($random(seed) & 1) != 0;
      wready  = !w_held && ($random(seed) & 1) != 0;
      arready = !r_wait && !rvalid && ($random(seed) & 1) != 0;
    end
  end

endmodule

// File: dv/lsq_tb.sv
// LSQ testbench; rob heads track pending memory ops and are at times held by older non-LSQ ops
module lsq_tb import lsq_pkg::*; ();

  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
  localparam int MEM_WORDS      = 16;
  // Live tags must stay unique modulo 32
  localparam int TAG_WINDOW     = 28;

  logic                    clock;
  logic                    reset;
  logic                    slot_0_valid;
  logic [TAG_WIDTH-1:0]    slot_0_tag;
  logic                    slot_0_load;
  logic                    slot_0_store;
  logic                    slot_1_valid;
  logic [TAG_WIDTH-1:0]    slot_1_tag;
  logic                    slot_1_load;
  logic                    slot_1_store;
  logic                    dispatch_ready;
  logic                    ex_0_valid;
  logic [TAG_WIDTH-1:0]    ex_0_tag;
  logic [ADDR_WIDTH-1:0]   ex_0_addr;
  logic [DATA_WIDTH-1:0]   ex_0_data;
  logic                    ex_1_valid;
  logic [TAG_WIDTH-1:0]    ex_1_tag;
  logic [ADDR_WIDTH-1:0]   ex_1_addr;
  logic [DATA_WIDTH-1:0]   ex_1_data;
  logic [TAG_WIDTH-1:0]    rob_head_0;
  logic [TAG_WIDTH-1:0]    rob_head_1;
  logic                    awvalid;
  logic                    awready;
  logic [ADDR_WIDTH-1:0]   awaddr;
  logic                    wvalid;
  logic                    wready;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic                    bvalid;
  logic                    bready;
  logic [1:0]              bresp;
  logic                    arvalid;
  logic                    arready;
  logic [ADDR_WIDTH-1:0]   araddr;
  logic                    rvalid;
  logic                    rready;
  logic [DATA_WIDTH-1:0]   rdata;
  logic [1:0]              rresp;
  logic                    done_valid;
  logic [TAG_WIDTH-1:0]    done_tag;
  logic                    done_load;
  logic [DATA_WIDTH-1:0]   done_data;

  ////////////////////
  // Reference model state
  ////////////////////

  integer                seed;
  int                    op_seq  [NUM_OPS];
  logic                  op_load [NUM_OPS];
  logic [ADDR_WIDTH-1:0] op_addr [NUM_OPS];
  logic [DATA_WIDTH-1:0] op_data [NUM_OPS];
  logic [DATA_WIDTH-1:0] mem_model [MEM_WORDS];
  // Memory ops by stage, all counted in program order
  int num_gen;
  int num_acc;
  int num_alloc;
  int num_pop;
  int num_done;
  int next_seq;
  int pair_ops;
  int pend[$];
  logic pair_pending;
  logic prev_ready;
  logic in_flight;

  lsq_top uut (.*);

  lsq_axi_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (.*);

  always #4 clock = ~clock;

  function automatic logic [TAG_WIDTH-1:0] seq_tag(input int seq);
    return TAG_WIDTH'(seq);
  endfunction

  function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
    return int'(addr >> 2) % MEM_WORDS;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] fill_word(input int i);
    return 32'h6d6d_0000 ^ (32'(i) << 2);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    assert (ok)
    else begin
      $display("error at %0t: %s", $time, what);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // One decoded slot; memory ops are recorded in program order
  task automatic pick_slot(output logic v, output logic [TAG_WIDTH-1:0] t,
                           output logic ld, output logic st);
    int kind;
    int oldest;
    v  = 1'b0;
    t  = '0;
    ld = 1'b0;
    st = 1'b0;
    oldest = next_seq;
    if (num_done < num_gen)
      oldest = op_seq[num_done];
    if (num_gen < NUM_OPS && next_seq - oldest < TAG_WINDOW &&
        ($unsigned($random(seed)) % 4) != 0) begin
      kind = $unsigned($random(seed)) % 3;
      v  = 1'b1;
      t  = seq_tag(next_seq);
      ld = (kind == 0);
      st = (kind == 1);
      if (kind != 2) begin
        op_seq[num_gen]  = next_seq;
        op_load[num_gen] = ld;
        op_addr[num_gen] = ($unsigned($random(seed)) % MEM_WORDS) * 4;
        op_data[num_gen] = $random(seed);
        num_gen++;
        pair_ops++;
      end
      next_seq++;
    end
  endtask

  // Results leave the pending list in random order
  task automatic drive_exec(output logic v, output logic [TAG_WIDTH-1:0] t,
                            output logic [ADDR_WIDTH-1:0] a, output logic [DATA_WIDTH-1:0] d);
    int k;
    int idx;
    v = 1'b0;
    t = '0;
    a = '0;
    d = '0;
    if (pend.size() > 0 && ($random(seed) & 1) != 0) begin
      k   = $unsigned($random(seed)) % pend.size();
      idx = pend[k];
      pend.delete(k);
      v = 1'b1;
      t = seq_tag(op_seq[idx]);
      a = op_addr[idx];
      d = op_load[idx] ? $random(seed) : op_data[idx];
    end
  endtask

  task automatic drive_rob_heads();
    int hold;
    int oldest;
    hold = $unsigned($random(seed)) % 4;
    rob_head_0 = seq_tag(next_seq);
    rob_head_1 = seq_tag(next_seq);
    if (num_done < num_gen)
      rob_head_0 = seq_tag(op_seq[num_done]);
    if (num_done + 1 < num_gen)
      rob_head_1 = seq_tag(op_seq[num_done + 1]);
    // Older ops outside the LSQ sometimes still hold the commit window
    if (num_done < num_gen && hold < 2) begin
      oldest     = op_seq[num_done];
      rob_head_0 = (hold == 0) ? seq_tag(oldest - 2) : seq_tag(oldest - 1);
      rob_head_1 = (hold == 0) ? seq_tag(oldest - 1) : seq_tag(oldest);
    end
  endtask

  // Runs at each falling edge and covers the rising edge just passed
  task automatic model_step();
    if (prev_ready) begin
      while (num_alloc < num_acc) begin
        pend.push_back(num_alloc);
        num_alloc++;
      end
      if (pair_pending) begin
        num_acc += pair_ops;
        pair_pending = 1'b0;
      end
    end
    if (done_valid === 1'b1) begin
      check_cond(num_done < num_pop, "completion reported with no memory op in flight");
      check_value("done_tag", done_tag, seq_tag(op_seq[num_done]));
      check_value("done_load", done_load, op_load[num_done]);
      if (op_load[num_done])
        check_value("done_data", done_data, mem_model[word_index(op_addr[num_done])]);
      else
        mem_model[word_index(op_addr[num_done])] = op_data[num_done];
      num_done++;
      in_flight = 1'b0;
    end
    // A new bus transaction means the head was popped at the last edge
    if (!in_flight && (arvalid === 1'b1 || awvalid === 1'b1 || wvalid === 1'b1)) begin
      check_cond(num_pop < num_alloc, "memory access for an op that is not in the queue");
      check_value("arvalid", arvalid, op_load[num_pop]);
      if (op_load[num_pop]) begin
        check_value("araddr", araddr, op_addr[num_pop]);
      end else begin
        check_value("awaddr", awaddr, op_addr[num_pop]);
        check_value("wdata", wdata, op_data[num_pop]);
        check_value("wstrb", wstrb, 4'hf);
        check_cond(seq_tag(op_seq[num_pop]) == rob_head_0 ||
                   seq_tag(op_seq[num_pop]) == rob_head_1,
                   "store reached memory outside the two oldest rob tags");
      end
      num_pop++;
      in_flight = 1'b1;
    end
    check_cond(num_alloc - num_pop <= LSQ_ENTRIES, "queue holds more ops than its depth");
    check_value("dispatch_ready", dispatch_ready, (num_alloc - num_pop) <= LSQ_ENTRIES - 2);
    prev_ready = dispatch_ready;
    // Pair stays on the slots until dispatch takes it
    if (!pair_pending) begin
      pair_ops = 0;
      pick_slot(slot_0_valid, slot_0_tag, slot_0_load, slot_0_store);
      pick_slot(slot_1_valid, slot_1_tag, slot_1_load, slot_1_store);
      pair_pending = slot_0_valid | slot_1_valid;
    end
    drive_exec(ex_0_valid, ex_0_tag, ex_0_addr, ex_0_data);
    drive_exec(ex_1_valid, ex_1_tag, ex_1_addr, ex_1_data);
    drive_rob_heads();
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin
    seed         = 32'h18c0_a548;
    clock        = 1'b0;
    reset        = 1'b1;
    slot_0_valid = 1'b0;
    slot_0_tag   = '0;
    slot_0_load  = 1'b0;
    slot_0_store = 1'b0;
    slot_1_valid = 1'b0;
    slot_1_tag   = '0;
    slot_1_load  = 1'b0;
    slot_1_store = 1'b0;
    ex_0_valid   = 1'b0;
    ex_0_tag     = '0;
    ex_0_addr    = '0;
    ex_0_data    = '0;
    ex_1_valid   = 1'b0;
    ex_1_tag     = '0;
    ex_1_addr    = '0;
    ex_1_data    = '0;
    num_gen      = 0;
    num_acc      = 0;
    num_alloc    = 0;
    num_pop      = 0;
    num_done     = 0;
    next_seq     = 0;
    pair_ops     = 0;
    pair_pending = 1'b0;
    prev_ready   = 1'b0;
    in_flight    = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem_model[i] = fill_word(i);
    drive_rob_heads();
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_value("dispatch_ready", dispatch_ready, 1'b1);
    check_value("done_valid", done_valid, 1'b0);
    check_value("awvalid", awvalid, 1'b0);
    check_value("wvalid", wvalid, 1'b0);
    check_value("arvalid", arvalid, 1'b0);
    check_value("bready", bready, 1'b0);
    check_value("rready", rready, 1'b0);
    while (num_done < NUM_OPS) begin
      @(negedge clock);
      model_step();
    end
    // Quiet tail catches duplicated completions
    repeat (20) begin
      @(negedge clock);
      model_step();
    end
    check_value("popped ops", num_pop, NUM_OPS);
    check_cond(pend.size() == 0, "execute results left undelivered");
    for (int i = 0; i < MEM_WORDS; i++)
      check_value("memory word", u_mem.mem[i], mem_model[i]);
    $display("TEST PASSED");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: flist.f
rtl/lsq_pkg.sv
rtl/lsq_entry.sv
rtl/lsq_dispatch.sv
rtl/lsq_queue.sv
rtl/lsq_mem_port.sv
rtl/lsq_top.sv
dv/lsq_axi_mem.sv
dv/lsq_tb.sv

// File: Bender.yml
package:
  name: lsq

sources:
  - files:
      - rtl/lsq_pkg.sv
      - rtl/lsq_entry.sv
      - rtl/lsq_dispatch.sv
      - rtl/lsq_queue.sv
      - rtl/lsq_mem_port.sv
      - rtl/lsq_top.sv
  - target: test
    files:
      - dv/lsq_axi_mem.sv
      - dv/lsq_tb.sv
